// ==== rvBusPkg.sv ====
//------------------------------------------------
// Wishbone classic bus types shared by the core,
// the arbiter, the RAM and the host port.
// Requests flow master to slave, responses back.
//------------------------------------------------
package rvBusPkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      // Byte lanes, all ones for word accesses
      logic [3:0] sel;
      addr_t      adr;
      word_t      dat;
   } wbReq_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wbRsp_t;

endpackage

// ==== rvIsaPkg.sv ====
//------------------------------------------------
// RV32I instruction-set definitions for the core.
// Major opcodes, ALU operations, writeback
// sources and the decoded-instruction bundle that
// travels from the decoder to execute and control.
//------------------------------------------------
package rvIsaPkg;

   typedef logic [31:0] inst_t;
   typedef logic [4:0]  regIdx_t;

   // Major opcodes, bits [6:0] of the instruction
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OPIMM  = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_SYSTEM = 7'b1110011
   } opcode_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
   } aluOp_t;

   typedef enum logic [1:0] {
      WB_ALU, WB_MEM, WB_LINK
   } wbSel_t;

   typedef struct packed {
      regIdx_t     rs1;
      regIdx_t     rs2;
      regIdx_t     rd;
      logic [31:0] imm;
      aluOp_t      aluOp;
      logic        srcAPc;
      logic        srcBImm;
      logic        isBranch;
      logic [2:0]  funct3;
      logic        isJal;
      logic        isJalr;
      logic        isLoad;
      logic        isStore;
      logic        regWrite;
      wbSel_t      wbSel;
      logic        isHalt;
      logic        illegal;
   } decoded_t;

endpackage

// ==== rvDecode.sv ====
//------------------------------------------------
// Combinational RV32I decoder. Splits a fetched
// instruction into register fields, builds the
// immediate and selects the datapath controls.
//------------------------------------------------
`timescale 1ns/1ps

module rvDecode
   import rvBusPkg::*;
   import rvIsaPkg::*;
(
   input  inst_t    inst,
   output decoded_t dec
);

   opcode_t    opcode;
   logic [2:0] funct3;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;

   function automatic aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  aluFromFunct3 = alt ? ALU_SUB : ALU_ADD;
         3'b001:  aluFromFunct3 = ALU_SLL;
         3'b010:  aluFromFunct3 = ALU_SLT;
         3'b011:  aluFromFunct3 = ALU_SLTU;
         3'b100:  aluFromFunct3 = ALU_XOR;
         3'b101:  aluFromFunct3 = alt ? ALU_SRA : ALU_SRL;
         3'b110:  aluFromFunct3 = ALU_OR;
         default: aluFromFunct3 = ALU_AND;
      endcase
   endfunction

   assign opcode = opcode_t'(inst[6:0]);
   assign funct3 = inst[14:12];

   // Immediate formats, all sign extended from bit 31
   assign immI = {{20{inst[31]}}, inst[31:20]};
   assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign immU = {inst[31:12], 12'b0};
   assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   always_comb
   begin
      dec = '0;
      dec.rs1 = inst[19:15];
      dec.rs2 = inst[24:20];
      dec.rd = inst[11:7];
      dec.funct3 = funct3;
      dec.aluOp = ALU_ADD;
      dec.wbSel = WB_ALU;
      case (opcode)
         OPC_LUI:
         begin
            dec.imm = immU;
            dec.aluOp = ALU_PASSB;
            dec.srcBImm = 1'b1;
            dec.regWrite = 1'b1;
         end
         OPC_AUIPC:
         begin
            dec.imm = immU;
            dec.srcAPc = 1'b1;
            dec.srcBImm = 1'b1;
            dec.regWrite = 1'b1;
         end
         OPC_JAL:
         begin
            dec.imm = immJ;
            dec.isJal = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel = WB_LINK;
         end
         OPC_JALR:
         begin
            dec.imm = immI;
            dec.srcBImm = 1'b1;
            dec.isJalr = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel = WB_LINK;
         end
         OPC_BRANCH:
         begin
            dec.imm = immB;
            dec.isBranch = 1'b1;
         end
         OPC_LOAD:
         begin
            dec.imm = immI;
            dec.srcBImm = 1'b1;
            dec.isLoad = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel = WB_MEM;
            // Only LW exists on this core
            dec.illegal = (funct3 != 3'b010);
         end
         OPC_STORE:
         begin
            dec.imm = immS;
            dec.srcBImm = 1'b1;
            dec.isStore = 1'b1;
            dec.illegal = (funct3 != 3'b010);
         end
         OPC_OPIMM:
         begin
            dec.imm = immI;
            dec.srcBImm = 1'b1;
            // Bit 30 selects SRAI only, elsewhere it is immediate
            dec.aluOp = aluFromFunct3(funct3, (funct3 == 3'b101) && inst[30]);
            dec.regWrite = 1'b1;
         end
         OPC_OP:
         begin
            dec.aluOp = aluFromFunct3(funct3, inst[30]);
            dec.regWrite = 1'b1;
         end
         OPC_SYSTEM:
         begin
            dec.isHalt = (inst == 32'h0010_0073);
            dec.illegal = (inst != 32'h0010_0073);
         end
         default:
            dec.illegal = 1'b1;
      endcase
   end

endmodule

// ==== rvExecute.sv ====
//------------------------------------------------
// Execute stage of the multi-cycle core. Selects
// ALU operands, resolves branches and computes
// the next PC and the link value for jumps.
//------------------------------------------------
`timescale 1ns/1ps

module rvExecute
   import rvBusPkg::*;
   import rvIsaPkg::*;
(
   input  decoded_t dec,
   input  addr_t    pc,
   input  word_t    rs1Val,
   input  word_t    rs2Val,
   output word_t    aluOut,
   output addr_t    nextPc,
   output word_t    linkVal
);

   word_t opA;
   word_t opB;
   addr_t pcPlus4;
   addr_t target;
   logic  taken;

   assign opA = dec.srcAPc ? pc : rs1Val;
   assign opB = dec.srcBImm ? dec.imm : rs2Val;

   always_comb
   begin
      case (dec.aluOp)
         ALU_ADD:   aluOut = opA + opB;
         ALU_SUB:   aluOut = opA - opB;
         ALU_SLL:   aluOut = opA << opB[4:0];
         ALU_SLT:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
         ALU_SLTU:  aluOut = {31'b0, opA < opB};
         ALU_XOR:   aluOut = opA ^ opB;
         ALU_SRL:   aluOut = opA >> opB[4:0];
         ALU_SRA:   aluOut = word_t'($signed(opA) >>> opB[4:0]);
         ALU_OR:    aluOut = opA | opB;
         ALU_AND:   aluOut = opA & opB;
         ALU_PASSB: aluOut = opB;
         default:   aluOut = '0;
      endcase
   end

   // Branch condition compares the raw register values
   always_comb
   begin
      case (dec.funct3)
         3'b000:  taken = (rs1Val == rs2Val);
         3'b001:  taken = (rs1Val != rs2Val);
         3'b100:  taken = ($signed(rs1Val) < $signed(rs2Val));
         3'b101:  taken = ($signed(rs1Val) >= $signed(rs2Val));
         3'b110:  taken = (rs1Val < rs2Val);
         3'b111:  taken = (rs1Val >= rs2Val);
         default: taken = 1'b0;
      endcase
   end

   assign pcPlus4 = pc + 32'd4;
   assign target = pc + dec.imm;
   assign linkVal = pcPlus4;

   always_comb
   begin
      if (dec.isJalr)
         nextPc = {aluOut[31:1], 1'b0};
      else if (dec.isJal || (dec.isBranch && taken))
         nextPc = target;
      else
         nextPc = pcPlus4;
   end

endmodule

// ==== rvRegFile.sv ====
//------------------------------------------------
// Integer register file, 32 x 32 bits.
// Two asynchronous read ports, one clocked write
// port; x0 always reads as zero.
//------------------------------------------------
`timescale 1ns/1ps

module rvRegFile
   import rvBusPkg::*;
   import rvIsaPkg::*;
(
   input  logic    clk,
   input  regIdx_t rs1,
   input  regIdx_t rs2,
   input  logic    we,
   input  regIdx_t rd,
   input  word_t   wd,
   output word_t   rs1Val,
   output word_t   rs2Val
);

   word_t regs [32];

   always_ff @(posedge clk)
   begin
      if (we && (rd != '0))
         regs[rd] <= wd;
   end

   assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

   // The core filters writes to x0 before they get here
   noWriteToZero: assert property (@(posedge clk) we |-> (rd != '0))
      else $error("register write to x0 with we high");

endmodule

// ==== rvCore.sv ====
//------------------------------------------------
// Multi-cycle RV32I core with one instruction in
// flight. Fetch and load/store are two Wishbone
// classic masters; the core waits for run, starts
// at ResetPc and halts on EBREAK or illegal code.
//------------------------------------------------
`timescale 1ns/1ps

module rvCore
   import rvBusPkg::*;
   import rvIsaPkg::*;
#(
   parameter addr_t ResetPc = '0
)
(
   input  logic   clk,
   input  logic   rst,
   input  logic   run,
   output wbReq_t fetchReq,
   input  wbRsp_t fetchRsp,
   output wbReq_t dataReq,
   input  wbRsp_t dataRsp,
   output logic   halted
);

   typedef enum logic [2:0] {
      IDLE, FETCH, EXEC, MEM, WB, HALT
   } coreState_t;

   coreState_t state;
   addr_t      pc;
   inst_t      instReg;
   decoded_t   dec;
   word_t      rs1Val;
   word_t      rs2Val;
   word_t      aluOut;
   addr_t      nextPc;
   word_t      linkVal;
   word_t      aluReg;
   addr_t      nextPcReg;
   word_t      linkReg;
   word_t      memData;
   word_t      wbData;
   logic       regWe;

   rvDecode decode (
      .inst (instReg),
      .dec  (dec)
   );

   rvRegFile regFile (
      .clk    (clk),
      .rs1    (dec.rs1),
      .rs2    (dec.rs2),
      .we     (regWe),
      .rd     (dec.rd),
      .wd     (wbData),
      .rs1Val (rs1Val),
      .rs2Val (rs2Val)
   );

   rvExecute execute (
      .dec     (dec),
      .pc      (pc),
      .rs1Val  (rs1Val),
      .rs2Val  (rs2Val),
      .aluOut  (aluOut),
      .nextPc  (nextPc),
      .linkVal (linkVal)
   );

   // Controller
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= IDLE;
         pc <= ResetPc;
      end
      else
      begin
         case (state)
            IDLE:
               if (run)
                  state <= FETCH;
            FETCH:
               if (fetchRsp.ack)
                  state <= EXEC;
            EXEC:
            begin
               if (dec.illegal || dec.isHalt)
                  state <= HALT;
               else if (dec.isLoad || dec.isStore)
                  state <= MEM;
               else
                  state <= WB;
            end
            MEM:
               if (dataRsp.ack)
                  state <= WB;
            WB:
            begin
               pc <= nextPcReg;
               state <= FETCH;
            end
            default:
               state <= HALT;
         endcase
      end
   end

   // Instruction and execute results, held until writeback
   always_ff @(posedge clk)
   begin
      if (state == FETCH && fetchRsp.ack)
         instReg <= fetchRsp.dat;
      if (state == EXEC)
      begin
         aluReg <= aluOut;
         nextPcReg <= nextPc;
         linkReg <= linkVal;
      end
      if (state == MEM && dataRsp.ack)
         memData <= dataRsp.dat;
   end

   // Both masters raise cyc only in their own state
   always_comb
   begin
      fetchReq = '0;
      fetchReq.cyc = (state == FETCH);
      fetchReq.stb = (state == FETCH);
      fetchReq.sel = 4'hF;
      fetchReq.adr = pc;

      dataReq = '0;
      dataReq.cyc = (state == MEM);
      dataReq.stb = (state == MEM);
      dataReq.we = dec.isStore;
      dataReq.sel = 4'hF;
      dataReq.adr = aluReg;
      dataReq.dat = rs2Val;
   end

   always_comb
   begin
      case (dec.wbSel)
         WB_MEM:  wbData = memData;
         WB_LINK: wbData = linkReg;
         default: wbData = aluReg;
      endcase
   end

   assign regWe = (state == WB) && dec.regWrite && (dec.rd != '0);
   assign halted = (state == HALT);

   // The shared RAM port must never see both core masters at once
   oneMasterActive: assert property (@(posedge clk) disable iff (rst)
      (fetchReq.cyc || fetchRsp.ack) |-> !(dataReq.cyc || dataRsp.ack))
      else $error("fetch and data transfers active together");

   dataAligned: assert property (@(posedge clk) disable iff (rst)
      dataReq.stb |-> (dataReq.adr[1:0] == 2'b00))
      else $error("misaligned data address %h", dataReq.adr);

endmodule

// ==== wbArbiter.sv ====
//------------------------------------------------
// Fixed-priority Wishbone classic arbiter for
// three masters onto one slave. Host wins over
// data, data over fetch; the grant is held until
// the owner drops cyc.
//------------------------------------------------
`timescale 1ns/1ps

module wbArbiter
   import rvBusPkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  wbReq_t hostReq,
   input  wbReq_t dataReq,
   input  wbReq_t fetchReq,
   output wbRsp_t hostRsp,
   output wbRsp_t dataRsp,
   output wbRsp_t fetchRsp,
   output wbReq_t memReq,
   input  wbRsp_t memRsp
);

   // One-hot owner, bit 2 host, bit 1 data, bit 0 fetch
   logic [2:0] owner;
   logic [2:0] pick;
   logic [2:0] cycVec;
   logic [2:0] stbVec;
   logic [2:0] ackVec;

   assign cycVec = {hostReq.cyc, dataReq.cyc, fetchReq.cyc};
   assign stbVec = {hostReq.stb, dataReq.stb, fetchReq.stb};

   always_comb
   begin
      if (cycVec[2])
         pick = 3'b100;
      else if (cycVec[1])
         pick = 3'b010;
      else if (cycVec[0])
         pick = 3'b001;
      else
         pick = 3'b000;
   end

   // Regrant only once the current owner has let go
   always_ff @(posedge clk)
   begin
      if (rst)
         owner <= '0;
      else if ((owner & cycVec) == '0)
         owner <= pick;
   end

   always_comb
   begin
      case (owner)
         3'b100:  memReq = hostReq;
         3'b010:  memReq = dataReq;
         3'b001:  memReq = fetchReq;
         default: memReq = '0;
      endcase
   end

   assign hostRsp = '{ack: memRsp.ack & owner[2], dat: memRsp.dat};
   assign dataRsp = '{ack: memRsp.ack & owner[1], dat: memRsp.dat};
   assign fetchRsp = '{ack: memRsp.ack & owner[0], dat: memRsp.dat};
   assign ackVec = {hostRsp.ack, dataRsp.ack, fetchRsp.ack};

   // An ack goes to one master only, and that master is still strobing
   ackToOwner: assert property (@(posedge clk) disable iff (rst)
      (|ackVec) |-> ($onehot(ackVec) && ((ackVec & stbVec) == ackVec)))
      else $error("ack reached a master that does not own the bus");

endmodule

// ==== wbRam.sv ====
//------------------------------------------------
// Single-port word RAM as a Wishbone classic
// slave. Ack and read data are registered, so a
// granted access completes in two cycles.
//------------------------------------------------
`timescale 1ns/1ps

module wbRam
   import rvBusPkg::*;
#(
   parameter int MemWords = 1024
)
(
   input  logic   clk,
   input  logic   rst,
   input  wbReq_t req,
   output wbRsp_t rsp
);

   localparam int IdxBits = $clog2(MemWords);

   word_t              mem [MemWords];
   word_t              rdData;
   logic               ack;
   logic               access;
   logic [IdxBits-1:0] idx;

   // A new access starts only when no ack is outstanding
   assign access = req.cyc && req.stb && !ack;
   assign idx = req.adr[IdxBits+1:2];

   always_ff @(posedge clk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= access;
   end

   always_ff @(posedge clk)
   begin
      if (access)
      begin
         rdData <= mem[idx];
         if (req.we)
         begin
            for (int lane = 0; lane < 4; lane++)
            begin
               if (req.sel[lane])
                  mem[idx][8*lane +: 8] <= req.dat[8*lane +: 8];
            end
         end
      end
   end

   assign rsp = '{ack: ack, dat: rdData};

   addrInRange: assert property (@(posedge clk) disable iff (rst)
      (req.cyc && req.stb) |-> (req.adr[31:2] < MemWords))
      else $error("RAM address %h beyond depth", req.adr);

endmodule

// ==== rvSystem.sv ====
//------------------------------------------------
// Processor subsystem top level. The core's fetch
// and data masters and the host port share one
// RAM through the arbiter. The host loads code
// before run and reads results after halted.
//------------------------------------------------
`timescale 1ns/1ps

module rvSystem
   import rvBusPkg::*;
#(
   parameter int    MemWords = 1024,
   parameter addr_t ResetPc  = '0
)
(
   input  logic   clk,
   input  logic   rst,
   input  logic   run,
   input  wbReq_t hostReq,
   output wbRsp_t hostRsp,
   output logic   halted
);

   wbReq_t fetchReq;
   wbRsp_t fetchRsp;
   wbReq_t dataReq;
   wbRsp_t dataRsp;
   wbReq_t memReq;
   wbRsp_t memRsp;

   rvCore #(
      .ResetPc (ResetPc)
   ) core (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .fetchReq (fetchReq),
      .fetchRsp (fetchRsp),
      .dataReq  (dataReq),
      .dataRsp  (dataRsp),
      .halted   (halted)
   );

   wbArbiter arbiter (
      .clk      (clk),
      .rst      (rst),
      .hostReq  (hostReq),
      .dataReq  (dataReq),
      .fetchReq (fetchReq),
      .hostRsp  (hostRsp),
      .dataRsp  (dataRsp),
      .fetchRsp (fetchRsp),
      .memReq   (memReq),
      .memRsp   (memRsp)
   );

   wbRam #(
      .MemWords (MemWords)
   ) ram (
      .clk (clk),
      .rst (rst),
      .req (memReq),
      .rsp (memRsp)
   );

endmodule

// ==== tbRvSystem.sv ====
//------------------------------------------------
// Testbench for the RV32I subsystem. Builds random
// programs, loads them over the host port, runs
// the core until halted and compares the stored
// registers and the data area with an ISA model.
//------------------------------------------------
`timescale 1ns/1ps

module tbRvSystem
   import rvBusPkg::*;
();

   localparam int    MemWords   = 1024;
   // Word indices, all reachable from x0 with a 12-bit offset
   localparam int    DataBase   = 256;
   localparam int    DataWords  = 64;
   localparam int    ResultBase = 448;
   localparam int    NumTests   = 8;
   localparam word_t Ebreak     = 32'h0010_0073;

   logic   clk;
   logic   rst;
   logic   run;
   wbReq_t hostReq;
   wbRsp_t hostRsp;
   logic   halted;

   word_t image [MemWords];
   word_t modelMem [MemWords];
   word_t modelRegs [32];
   int    progLen;
   int    errors;
   int    checks;

   rvSystem #(
      .MemWords (MemWords),
      .ResetPc  (32'h0)
   ) UUT (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .hostReq (hostReq),
      .hostRsp (hostRsp),
      .halted  (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Instruction encoders
   function automatic word_t rType(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      rType = {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t iType(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
      iType = {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t sType(input logic [11:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      sType = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t bType(input logic [12:0] off, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      bType = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic word_t jType(input logic [20:0] off, input logic [4:0] rd);
      jType = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic void emitInst(input word_t inst);
      image[progLen] = inst;
      progLen++;
   endfunction

   function automatic logic [11:0] dataByte();
      dataByte = 12'((DataBase + $urandom_range(0, DataWords - 1)) * 4);
   endfunction

   // Signed and unsigned boundaries show up often
   function automatic word_t pickSeedValue();
      case ($urandom_range(0, 5))
         0:       pickSeedValue = 32'h8000_0000;
         1:       pickSeedValue = 32'h7FFF_FFFF;
         2:       pickSeedValue = 32'hFFFF_FFFF;
         3:       pickSeedValue = 32'h0000_0001;
         4:       pickSeedValue = 32'h0000_0000;
         default: pickSeedValue = $urandom;
      endcase
   endfunction

   function automatic word_t aluResult(input logic [2:0] f3, input logic alt,
         input word_t a, input word_t b);
      case (f3)
         3'd0: aluResult = alt ? a - b : a + b;
         3'd1: aluResult = a << b[4:0];
         3'd2: aluResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: aluResult = (a < b) ? 32'd1 : 32'd0;
         3'd4: aluResult = a ^ b;
         3'd5:
         begin
            if (alt)
               aluResult = $signed(a) >>> b[4:0];
            else
               aluResult = a >> b[4:0];
         end
         3'd6: aluResult = a | b;
         default: aluResult = a & b;
      endcase
   endfunction

   // LUI rounds up so that the sign-extended ADDI lands on the value
   task automatic loadConst(input logic [4:0] rd, input word_t value);
      word_t upper;
      upper = value + 32'h800;
      emitInst({upper[31:12], rd, 7'b0110111});
      emitInst(iType(value[11:0], rd, 3'b000, rd, 7'b0010011));
   endtask

   task automatic randomBody(input int count);
      int          segEnd;
      int          reach;
      int          hop;
      int          cond;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [11:0] imm;
      word_t       r;
      segEnd = progLen + count;
      for (int i = 0; i < count; i++)
      begin
         // Jumps stay forward and end at the latest on the segment end
         reach = (segEnd - progLen < 4) ? segEnd - progLen : 4;
         hop = $urandom_range(1, reach);
         rd = $urandom_range(0, 31);
         rs1 = $urandom_range(0, 31);
         rs2 = $urandom_range(0, 31);
         f3 = $urandom_range(0, 7);
         r = $urandom;
         case ($urandom_range(0, 9))
            0, 1:
               emitInst(rType(((f3 == 3'd0 || f3 == 3'd5) && r[0]) ? 7'h20 : 7'h00,
                  rs2, rs1, f3, rd));
            2, 3:
            begin
               if (f3 == 3'd1)
                  imm = {7'h00, r[4:0]};
               else if (f3 == 3'd5)
                  imm = {r[5] ? 7'h20 : 7'h00, r[4:0]};
               else
                  imm = r[31:20];
               emitInst(iType(imm, rs1, f3, rd, 7'b0010011));
            end
            4:
               emitInst({r[31:12], rd, r[0] ? 7'b0010111 : 7'b0110111});
            5:
               emitInst(iType(dataByte(), 5'd0, 3'b010, rd, 7'b0000011));
            6:
               emitInst(sType(dataByte(), rs2, 5'd0));
            7:
            begin
               // Equal operands make taken branches common
               if (r[1:0] == 2'b00)
                  rs2 = rs1;
               cond = $urandom_range(0, 5);
               f3 = (cond < 2) ? 3'(cond) : 3'(cond + 2);
               emitInst(bType(13'(hop * 4), rs2, rs1, f3));
            end
            8:
               emitInst(jType(21'(hop * 4), rd));
            default:
               emitInst(iType(12'((progLen + hop) * 4), 5'd0, 3'b000, rd, 7'b1100111));
         endcase
      end
   endtask

   task automatic storeRegisters();
      for (int r = 1; r < 32; r++)
         emitInst(sType(12'((ResultBase + r - 1) * 4), 5'(r), 5'd0));
   endtask

   task automatic buildProgram(input bit withIllegal);
      progLen = 0;
      for (int r = 1; r < 32; r++)
         loadConst(5'(r), pickSeedValue());
      randomBody($urandom_range(20, 40));
      storeRegisters();
      if (withIllegal)
      begin
         // Unknown opcode, the second store pass must never run
         emitInst(32'h0000_0000);
         randomBody(20);
         storeRegisters();
      end
      emitInst(Ebreak);
   endtask

   task automatic modelExecute();
      addr_t      pc;
      addr_t      nextPc;
      addr_t      ea;
      word_t      inst;
      word_t      a;
      word_t      b;
      word_t      res;
      word_t      immI;
      logic [2:0] f3;
      logic       wr;
      logic       take;
      bit         done;
      int         steps;
      pc = '0;
      done = 1'b0;
      steps = 0;
      for (int r = 0; r < 32; r++)
         modelRegs[r] = '0;
      while (!done && steps < 4000)
      begin
         inst = modelMem[pc[11:2]];
         f3 = inst[14:12];
         a = modelRegs[inst[19:15]];
         b = modelRegs[inst[24:20]];
         immI = {{20{inst[31]}}, inst[31:20]};
         res = '0;
         wr = 1'b0;
         nextPc = pc + 32'd4;
         case (inst[6:0])
            7'b0110111:
            begin
               res = {inst[31:12], 12'b0};
               wr = 1'b1;
            end
            7'b0010111:
            begin
               res = pc + {inst[31:12], 12'b0};
               wr = 1'b1;
            end
            7'b1101111:
            begin
               res = pc + 32'd4;
               wr = 1'b1;
               nextPc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'b1100111:
            begin
               res = pc + 32'd4;
               wr = 1'b1;
               nextPc = (a + immI) & ~32'd1;
            end
            7'b1100011:
            begin
               case (f3)
                  3'd0:    take = (a == b);
                  3'd1:    take = (a != b);
                  3'd4:    take = ($signed(a) < $signed(b));
                  3'd5:    take = ($signed(a) >= $signed(b));
                  3'd6:    take = (a < b);
                  default: take = (a >= b);
               endcase
               if (take)
                  nextPc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            7'b0000011:
            begin
               ea = a + immI;
               res = modelMem[ea[11:2]];
               wr = 1'b1;
            end
            7'b0100011:
            begin
               ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
               modelMem[ea[11:2]] = b;
            end
            7'b0010011:
            begin
               res = aluResult(f3, inst[30] && (f3 == 3'd5), a, immI);
               wr = 1'b1;
            end
            7'b0110011:
            begin
               res = aluResult(f3, inst[30], a, b);
               wr = 1'b1;
            end
            // EBREAK, any other SYSTEM word and unknown opcodes all stop
            default:
               done = 1'b1;
         endcase
         if (!done && wr && inst[11:7] != 5'd0)
            modelRegs[inst[11:7]] = res;
         pc = nextPc;
         steps++;
      end
   endtask

   task automatic resetDut();
      @(posedge clk);
      rst <= 1'b1;
      run <= 1'b0;
      hostReq <= '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
   endtask

   // One Wishbone classic transfer on the host port
   task automatic busTransfer(input logic we, input addr_t adr, input word_t wdat,
         output word_t rdat);
      int   waitCycles;
      logic acked;
      @(posedge clk);
      hostReq <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: 4'hF, adr: adr, dat: wdat};
      waitCycles = 0;
      acked = 1'b0;
      rdat = 'x;
      while (!acked && waitCycles < 50)
      begin
         @(posedge clk);
         waitCycles++;
         if (hostRsp.ack === 1'b1)
         begin
            acked = 1'b1;
            rdat = hostRsp.dat;
         end
      end
      hostReq <= '0;
      if (!acked)
      begin
         errors++;
         $display("Host access to address %h got no ack", adr);
      end
   endtask

   task automatic writeWord(input addr_t adr, input word_t dat);
      word_t unused;
      busTransfer(1'b1, adr, dat, unused);
   endtask

   task automatic readWord(input addr_t adr, output word_t dat);
      busTransfer(1'b0, adr, '0, dat);
   endtask

   task automatic checkHostPort();
      int    addrs [16];
      word_t got;
      resetDut();
      for (int i = 0; i < 16; i++)
      begin
         addrs[i] = $urandom_range(0, MemWords - 1);
         modelMem[addrs[i]] = $urandom;
         writeWord(addrs[i] * 4, modelMem[addrs[i]]);
      end
      for (int i = 0; i < 16; i++)
      begin
         readWord(addrs[i] * 4, got);
         checks++;
         if (got !== modelMem[addrs[i]])
         begin
            errors++;
            $display("error: hostRsp.dat at %h = %h, expected %h",
               addrs[i] * 4, got, modelMem[addrs[i]]);
         end
      end
      checks++;
      if (halted !== 1'b0)
      begin
         errors++;
         $display("error: halted = %h before run, expected 0", halted);
      end
   endtask

   task automatic runAndCompare(input int testId);
      int    limit;
      int    cycles;
      word_t got;
      resetDut();
      for (int i = 0; i < DataWords; i++)
         image[DataBase + i] = $urandom;
      // Marker in the result area shows words the program never stored
      for (int i = 0; i < 31; i++)
         image[ResultBase + i] = {16'hDEAD, 16'(ResultBase + i)};
      for (int i = 0; i < progLen; i++)
         writeWord(i * 4, image[i]);
      for (int i = DataBase; i < DataBase + DataWords; i++)
         writeWord(i * 4, image[i]);
      for (int i = ResultBase; i < ResultBase + 31; i++)
         writeWord(i * 4, image[i]);
      modelMem = image;
      modelExecute();
      checks++;
      if (halted !== 1'b0)
      begin
         errors++;
         $display("error: halted = %h before run in test %0d, expected 0", halted, testId);
      end
      @(posedge clk);
      run <= 1'b1;
      limit = 12 * progLen + 100;
      cycles = 0;
      while (halted !== 1'b1 && cycles < limit)
      begin
         @(posedge clk);
         cycles++;
      end
      run <= 1'b0;
      checks++;
      if (halted !== 1'b1)
      begin
         errors++;
         $display("Test %0d: core did not halt within %0d cycles", testId, limit);
      end
      for (int r = 1; r < 32; r++)
      begin
         readWord((ResultBase + r - 1) * 4, got);
         checks++;
         if (got !== modelMem[ResultBase + r - 1])
         begin
            errors++;
            $display("error: test %0d x%0d = %h, expected %h",
               testId, r, got, modelMem[ResultBase + r - 1]);
         end
      end
      for (int i = DataBase; i < DataBase + DataWords; i++)
      begin
         readWord(i * 4, got);
         checks++;
         if (got !== modelMem[i])
         begin
            errors++;
            $display("error: test %0d mem[%h] = %h, expected %h", testId, i * 4, got, modelMem[i]);
         end
      end
   endtask

   initial
   begin
      rst = 1'b1;
      run = 1'b0;
      hostReq = '0;
      errors = 0;
      checks = 0;
      progLen = 0;
      void'($urandom(17));
      checkHostPort();
      for (int t = 0; t < NumTests; t++)
      begin
         // Every fourth program holds an unknown opcode
         buildProgram(t % 4 == 3);
         runAndCompare(t);
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== compile.f ====
rvBusPkg.sv
rvIsaPkg.sv
rvDecode.sv
rvExecute.sv
rvRegFile.sv
rvCore.sv
wbArbiter.sv
wbRam.sv
rvSystem.sv
tbRvSystem.sv

// ==== Bender.yml ====
package:
  name: rvsystem

sources:
  - files:
      - rvBusPkg.sv
      - rvIsaPkg.sv
      - rvDecode.sv
      - rvExecute.sv
      - rvRegFile.sv
      - rvCore.sv
      - wbArbiter.sv
      - wbRam.sv
      - rvSystem.sv
  - target: test
    files:
      - tbRvSystem.sv
